// File: filelist.f
logic/noc_pkg.sv
logic/noc_link_if.sv
logic/noc_input_port.sv
logic/noc_output_arb.sv
logic/noc_router.sv
logic/noc_narrow_wide_router.sv
test/noc_router_checker.sv
test/tb_noc_router.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_noc_router
RTL_TOP   ?= noc_narrow_wide_router
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

RTL_FILES = $(filter logic/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_noc_router.sv
// Testbench top driving random traffic through the narrow/wide router node
`timescale 1ns/1ns

module tb_noc_router;

  // The cycle limit scales with the flits sent by all tests
  localparam int total_flits = 2 * 15 * 16 + 15 * 16 + 5 * 6 + 10 * 12 + 5 * 4 + 5 * 40;
  localparam int cycle_limit = 40 * total_flits;

  logic clk = 1'b0;
  logic rst_n;
  noc_pkg::xy_id_t xy_id;
  logic [2:0][4:0] in_valid, in_ready, out_valid, out_ready, stall, acc_q;
  logic [2:0][4:0][67:0] in_flit, out_flit;
  noc_pkg::narrow_flit_t [4:0] nreq_flit_i, nreq_flit_o, nrsp_flit_i, nrsp_flit_o;
  noc_pkg::wide_flit_t [4:0] wide_flit_i, wide_flit_o;
  int remaining [3][5];
  int seq [3][5];
  int base [5];
  logic [31:0] lfsr = 32'hde86_cf27;
  logic throttle, continuous, fixed_dst, saw_low;
  noc_pkg::xy_id_t target;
  int cycles = 0, tests = 0, failed = 0, tb_errors = 0, mark;

  always #50 clk = ~clk;

  for (genvar i = 0; i < 5; i++) begin : gen_map
    assign nreq_flit_i[i] = {in_flit[0][i][67:64], in_flit[0][i][31:0]};
    assign nrsp_flit_i[i] = {in_flit[1][i][67:64], in_flit[1][i][31:0]};
    assign wide_flit_i[i] = in_flit[2][i];
    assign out_flit[0][i] = {nreq_flit_o[i][35:32], 32'h0, nreq_flit_o[i][31:0]};
    assign out_flit[1][i] = {nrsp_flit_o[i][35:32], 32'h0, nrsp_flit_o[i][31:0]};
    assign out_flit[2][i] = wide_flit_o[i];
  end

  noc_narrow_wide_router i_dut (
    .clk_i (clk), .rst_n_i (rst_n), .xy_id_i (xy_id),
    .narrow_req_valid_i (in_valid[0]), .narrow_req_ready_o (in_ready[0]),
    .narrow_req_flit_i (nreq_flit_i), .narrow_req_valid_o (out_valid[0]),
    .narrow_req_ready_i (out_ready[0]), .narrow_req_flit_o (nreq_flit_o),
    .narrow_rsp_valid_i (in_valid[1]), .narrow_rsp_ready_o (in_ready[1]),
    .narrow_rsp_flit_i (nrsp_flit_i), .narrow_rsp_valid_o (out_valid[1]),
    .narrow_rsp_ready_i (out_ready[1]), .narrow_rsp_flit_o (nrsp_flit_o),
    .wide_valid_i (in_valid[2]), .wide_ready_o (in_ready[2]), .wide_flit_i (wide_flit_i),
    .wide_valid_o (out_valid[2]), .wide_ready_i (out_ready[2]), .wide_flit_o (wide_flit_o)
  );

  noc_router_checker i_checker (
    .clk_i (clk), .rst_n_i (rst_n), .xy_id_i (xy_id),
    .in_valid_i (in_valid), .in_ready_i (in_ready), .in_flit_i (in_flit),
    .out_valid_i (out_valid), .out_ready_i (out_ready), .out_flit_i (out_flit)
  );

  always @(posedge clk) begin
    acc_q <= in_valid & in_ready;
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: no progress after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
    end
    return r;
  endfunction

  task automatic drive_cycle();
    logic [31:0] pl;
    @(negedge clk);
    for (int l = 0; l < 3; l++) begin
      for (int i = 0; i < 5; i++) begin
        if (in_valid[l][i] && acc_q[l][i]) in_valid[l][i] = 1'b0;
        if (!in_valid[l][i] && remaining[l][i] > 0 && (continuous || rand_bits(1) != 0)) begin
          // Link, input port and sequence number identify each flit
          pl = {2'(l), 3'(i), 27'(seq[l][i])};
          in_flit[l][i]  = {fixed_dst ? target : 4'(rand_bits(4)), (l == 2) ? ~pl : 32'h0, pl};
          in_valid[l][i] = 1'b1;
          seq[l][i]++;
          remaining[l][i]--;
        end
        out_ready[l][i] = !stall[l][i] && (!throttle || rand_bits(2) != 0);
      end
    end
  endtask

  task automatic load_flits(input int n, input logic [2:0] links);
    for (int l = 0; l < 3; l++)
      for (int i = 0; i < 5; i++)
        if (links[l]) remaining[l][i] = n;
  endtask

  task automatic run_until_idle(input logic [2:0] links);
    logic busy;
    busy = 1'b1;
    while (busy) begin
      drive_cycle();
      busy = 1'b0;
      for (int l = 0; l < 3; l++) begin
        if (links[l] && i_checker.pending[l] != 0) busy = 1'b1;
        for (int i = 0; i < 5; i++)
          if (links[l] && (remaining[l][i] != 0 || in_valid[l][i])) busy = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = i_checker.error_count + tb_errors - mark;
    tests++;
    if (errs != 0) failed++;
    $display("%-22s %s (%0d errors)", name, (errs == 0) ? "ok" : "failing", errs);
    mark = i_checker.error_count + tb_errors;
  endtask

  initial begin
    rst_n = 1'b0;
    xy_id = 4'h6;
    in_valid = '0;
    in_flit = '0;
    out_ready = '0;
    stall = '0;
    throttle = 1'b1;
    continuous = 1'b0;
    fixed_dst = 1'b0;
    target = '0;
    mark = 0;
    for (int l = 0; l < 3; l++)
      for (int i = 0; i < 5; i++) begin
        remaining[l][i] = 0;
        seq[l][i] = 0;
      end
    repeat (2) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;
    @(negedge clk);
    if (out_valid !== '0 || in_ready !== '1) begin
      $display("Fail %0t: reset state wrong, valid outputs %h, ready outputs %h",
               $time, out_valid, in_ready);
      tb_errors++;
    end
    finish_test("reset state");

    load_flits(16, 3'b111);
    run_until_idle(3'b111);
    xy_id = 4'h9;
    load_flits(16, 3'b111);
    run_until_idle(3'b111);
    finish_test("xy routing");

    xy_id = 4'hc;
    load_flits(16, 3'b111);
    run_until_idle(3'b111);
    finish_test("ordering");

    // Everything to the north output of the request link, which is stalled
    xy_id = 4'h5;
    fixed_dst = 1'b1;
    target = 4'h7;
    stall[0][0] = 1'b1;
    saw_low = 1'b0;
    load_flits(6, 3'b001);
    repeat (30) begin
      drive_cycle();
      if (in_ready[0] != '1) saw_low = 1'b1;
    end
    if (!saw_low) begin
      $display("Stalled output never pushed back on its inputs");
      tb_errors++;
    end
    stall = '0;
    run_until_idle(3'b001);
    finish_test("back-pressure");

    fixed_dst = 1'b0;
    stall[2] = '1;
    load_flits(12, 3'b011);
    load_flits(4, 3'b100);
    run_until_idle(3'b011);
    if (i_checker.pending[2] == 0) begin
      $display("Wide flits left a stalled link");
      tb_errors++;
    end
    stall = '0;
    run_until_idle(3'b111);
    finish_test("link independence");

    xy_id = 4'ha;
    target = 4'ha;
    fixed_dst = 1'b1;
    continuous = 1'b1;
    throttle = 1'b0;
    for (int i = 0; i < 5; i++) base[i] = i_checker.xfer_count[1][i];
    load_flits(40, 3'b010);
    repeat (25) drive_cycle();
    for (int i = 0; i < 5; i++)
      if (i_checker.xfer_count[1][i] - base[i] < 3) begin
        $display("Input %0d starved on the local output", i);
        tb_errors++;
      end
    run_until_idle(3'b010);
    finish_test("arbitration");

    $display("%0d tests, %0d failing, %0d checker errors, %0d other errors",
             tests, failed, i_checker.error_count, tb_errors);
    if (failed == 0 && tb_errors == 0 && i_checker.error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: test/noc_router_checker.sv
// Router monitor, queues accepted flits per input/output pair and checks every output
`timescale 1ns/1ns

module noc_router_checker (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input noc_pkg::xy_id_t       xy_id_i,
  input logic [2:0][4:0]       in_valid_i,
  input logic [2:0][4:0]       in_ready_i,
  input logic [2:0][4:0][67:0] in_flit_i,
  input logic [2:0][4:0]       out_valid_i,
  input logic [2:0][4:0]       out_ready_i,
  input logic [2:0][4:0][67:0] out_flit_i
);

  logic [67:0] exp_q [75][$];
  logic [2:0][4:0] held_q = '0;
  logic [2:0][4:0][67:0] held_flit_q;
  int pending [3] = '{0, 0, 0};
  int xfer_count [3][5];
  int error_count = 0;

  initial begin
    for (int l = 0; l < 3; l++)
      for (int i = 0; i < 5; i++) xfer_count[l][i] = 0;
  end

  // X first, then Y, else local
  function automatic int xy_dir(input logic [3:0] dst, input logic [3:0] node);
    if (dst[3:2] > node[3:2]) return 1;
    if (dst[3:2] < node[3:2]) return 3;
    if (dst[1:0] > node[1:0]) return 0;
    if (dst[1:0] < node[1:0]) return 2;
    return 4;
  endfunction

  always @(posedge clk_i) begin
    int src;
    logic [67:0] exp;
    if (rst_n_i) begin
      for (int l = 0; l < 3; l++) begin
        for (int o = 0; o < 5; o++) begin
          if (held_q[l][o] && (!out_valid_i[l][o] || out_flit_i[l][o] != held_flit_q[l][o])) begin
            $display("Fail %0t: link %0d out %0d changed while stalled, was %h now %h",
                     $time, l, o, held_flit_q[l][o], out_flit_i[l][o]);
            error_count++;
          end
          held_q[l][o]      <= out_valid_i[l][o] && !out_ready_i[l][o];
          held_flit_q[l][o] <= out_flit_i[l][o];
          if (out_valid_i[l][o] && out_ready_i[l][o]) begin
            src = out_flit_i[l][o][29:27];
            if (src > 4 || exp_q[l*25 + src*5 + o].size() == 0) begin
              $display("Fail %0t: link %0d out %0d unexpected flit %h",
                       $time, l, o, out_flit_i[l][o]);
              error_count++;
            end else begin
              exp = exp_q[l*25 + src*5 + o].pop_front();
              pending[l]--;
              xfer_count[l][src]++;
              if (exp != out_flit_i[l][o]) begin
                $display("Fail %0t: link %0d out %0d expected %h got %h",
                         $time, l, o, exp, out_flit_i[l][o]);
                error_count++;
              end
            end
          end
        end
        for (int i = 0; i < 5; i++) begin
          if (in_valid_i[l][i] && in_ready_i[l][i]) begin
            exp_q[l*25 + i*5 + xy_dir(in_flit_i[l][i][67:64], xy_id_i)].push_back(in_flit_i[l][i]);
            pending[l]++;
          end
        end
      end
    end
  end

endmodule

// File: logic/noc_narrow_wide_router.sv
// Router node with separate narrow request, narrow response and wide links
`timescale 1ns/1ns

module noc_narrow_wide_router (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  noc_pkg::xy_id_t                                 xy_id_i,

  input  logic [noc_pkg::num_dirs-1:0]                    narrow_req_valid_i,
  output logic [noc_pkg::num_dirs-1:0]                    narrow_req_ready_o,
  input  noc_pkg::narrow_flit_t [noc_pkg::num_dirs-1:0]   narrow_req_flit_i,
  output logic [noc_pkg::num_dirs-1:0]                    narrow_req_valid_o,
  input  logic [noc_pkg::num_dirs-1:0]                    narrow_req_ready_i,
  output noc_pkg::narrow_flit_t [noc_pkg::num_dirs-1:0]   narrow_req_flit_o,

  input  logic [noc_pkg::num_dirs-1:0]                    narrow_rsp_valid_i,
  output logic [noc_pkg::num_dirs-1:0]                    narrow_rsp_ready_o,
  input  noc_pkg::narrow_flit_t [noc_pkg::num_dirs-1:0]   narrow_rsp_flit_i,
  output logic [noc_pkg::num_dirs-1:0]                    narrow_rsp_valid_o,
  input  logic [noc_pkg::num_dirs-1:0]                    narrow_rsp_ready_i,
  output noc_pkg::narrow_flit_t [noc_pkg::num_dirs-1:0]   narrow_rsp_flit_o,

  input  logic [noc_pkg::num_dirs-1:0]                    wide_valid_i,
  output logic [noc_pkg::num_dirs-1:0]                    wide_ready_o,
  input  noc_pkg::wide_flit_t [noc_pkg::num_dirs-1:0]     wide_flit_i,
  output logic [noc_pkg::num_dirs-1:0]                    wide_valid_o,
  input  logic [noc_pkg::num_dirs-1:0]                    wide_ready_i,
  output noc_pkg::wide_flit_t [noc_pkg::num_dirs-1:0]     wide_flit_o
);

  localparam int unsigned nw = noc_pkg::narrow_payload_width;
  localparam int unsigned ww = noc_pkg::wide_payload_width;
  localparam int unsigned iw = noc_pkg::xy_id_width;

  noc_link_if #(.payload_width(nw)) narrow_req_in  [noc_pkg::num_dirs] ();
  noc_link_if #(.payload_width(nw)) narrow_req_out [noc_pkg::num_dirs] ();
  noc_link_if #(.payload_width(nw)) narrow_rsp_in  [noc_pkg::num_dirs] ();
  noc_link_if #(.payload_width(nw)) narrow_rsp_out [noc_pkg::num_dirs] ();
  noc_link_if #(.payload_width(ww)) wide_in        [noc_pkg::num_dirs] ();
  noc_link_if #(.payload_width(ww)) wide_out       [noc_pkg::num_dirs] ();

  // Split flits into destination and payload, join them on the way out
  for (genvar i = 0; i < noc_pkg::num_dirs; i++) begin : gen_port
    assign narrow_req_in[i].valid   = narrow_req_valid_i[i];
    assign narrow_req_in[i].dst     = narrow_req_flit_i[i][nw +: iw];
    assign narrow_req_in[i].payload = narrow_req_flit_i[i][nw-1:0];
    assign narrow_req_ready_o[i]    = narrow_req_in[i].ready;
    assign narrow_req_valid_o[i]    = narrow_req_out[i].valid;
    assign narrow_req_out[i].ready  = narrow_req_ready_i[i];
    assign narrow_req_flit_o[i]     = {narrow_req_out[i].dst, narrow_req_out[i].payload};

    assign narrow_rsp_in[i].valid   = narrow_rsp_valid_i[i];
    assign narrow_rsp_in[i].dst     = narrow_rsp_flit_i[i][nw +: iw];
    assign narrow_rsp_in[i].payload = narrow_rsp_flit_i[i][nw-1:0];
    assign narrow_rsp_ready_o[i]    = narrow_rsp_in[i].ready;
    assign narrow_rsp_valid_o[i]    = narrow_rsp_out[i].valid;
    assign narrow_rsp_out[i].ready  = narrow_rsp_ready_i[i];
    assign narrow_rsp_flit_o[i]     = {narrow_rsp_out[i].dst, narrow_rsp_out[i].payload};

    assign wide_in[i].valid   = wide_valid_i[i];
    assign wide_in[i].dst     = wide_flit_i[i][ww +: iw];
    assign wide_in[i].payload = wide_flit_i[i][ww-1:0];
    assign wide_ready_o[i]    = wide_in[i].ready;
    assign wide_valid_o[i]    = wide_out[i].valid;
    assign wide_out[i].ready  = wide_ready_i[i];
    assign wide_flit_o[i]     = {wide_out[i].dst, wide_out[i].payload};
  end

  noc_router #(
    .payload_width ( nw )
  ) i_narrow_req_router (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .node_id_i ( xy_id_i        ),
    .in_link   ( narrow_req_in  ),
    .out_link  ( narrow_req_out )
  );

  noc_router #(
    .payload_width ( nw )
  ) i_narrow_rsp_router (
    .clk_i     ( clk_i          ),
    .rst_n_i   ( rst_n_i        ),
    .node_id_i ( xy_id_i        ),
    .in_link   ( narrow_rsp_in  ),
    .out_link  ( narrow_rsp_out )
  );

  noc_router #(
    .payload_width ( ww )
  ) i_wide_router (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .node_id_i ( xy_id_i  ),
    .in_link   ( wide_in  ),
    .out_link  ( wide_out )
  );

endmodule

// File: logic/noc_router.sv
// Five-port XY router for one physical link, input FIFOs and output arbiters
`timescale 1ns/1ns

module noc_router #(
  parameter int unsigned payload_width = 32
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  noc_pkg::xy_id_t node_id_i,
  noc_link_if.receiver    in_link  [noc_pkg::num_dirs],
  noc_link_if.sender      out_link [noc_pkg::num_dirs]
);

  // Indexed by input port
  noc_pkg::dir_mask_t [noc_pkg::num_dirs-1:0]                 route_req;
  noc_pkg::xy_id_t [noc_pkg::num_dirs-1:0]                    head_dst;
  logic [noc_pkg::num_dirs-1:0][payload_width-1:0]            head_payload;
  logic [noc_pkg::num_dirs-1:0]                               pop;

  // Indexed by output port
  noc_pkg::dir_mask_t [noc_pkg::num_dirs-1:0]                 out_req;
  noc_pkg::dir_mask_t [noc_pkg::num_dirs-1:0]                 grant;

  for (genvar i = 0; i < noc_pkg::num_dirs; i++) begin : gen_input
    noc_input_port #(
      .payload_width ( payload_width )
    ) i_input_port (
      .clk_i          ( clk_i           ),
      .rst_n_i        ( rst_n_i         ),
      .in             ( in_link[i]      ),
      .node_id_i      ( node_id_i       ),
      .pop_i          ( pop[i]          ),
      .head_dst_o     ( head_dst[i]     ),
      .head_payload_o ( head_payload[i] ),
      .route_req_o    ( route_req[i]    )
    );
  end

  // Transpose requests so each output sees one bit per input
  always_comb begin
    for (int unsigned o = 0; o < noc_pkg::num_dirs; o++) begin
      for (int unsigned i = 0; i < noc_pkg::num_dirs; i++) begin
        out_req[o][i] = route_req[i][o];
      end
    end
  end

  for (genvar o = 0; o < noc_pkg::num_dirs; o++) begin : gen_output
    noc_output_arb #(
      .payload_width ( payload_width )
    ) i_output_arb (
      .clk_i     ( clk_i        ),
      .rst_n_i   ( rst_n_i      ),
      .req_i     ( out_req[o]   ),
      .dst_i     ( head_dst     ),
      .payload_i ( head_payload ),
      .out       ( out_link[o]  ),
      .grant_o   ( grant[o]     )
    );
  end

  // An input leaves at most one output per cycle, OR is enough
  always_comb begin
    pop = '0;
    for (int unsigned i = 0; i < noc_pkg::num_dirs; i++) begin
      for (int unsigned o = 0; o < noc_pkg::num_dirs; o++) begin
        pop[i] = pop[i] | grant[o][i];
      end
    end
  end

endmodule

// File: logic/noc_output_arb.sv
// Round-robin arbiter and flit multiplexer for one router output
`timescale 1ns/1ns

module noc_output_arb #(
  parameter int unsigned payload_width = 32
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  noc_pkg::dir_mask_t                                  req_i,
  input  noc_pkg::xy_id_t [noc_pkg::num_dirs-1:0]             dst_i,
  input  logic [noc_pkg::num_dirs-1:0][payload_width-1:0]     payload_i,
  noc_link_if.sender                                          out,
  output noc_pkg::dir_mask_t                                  grant_o
);

  noc_pkg::dir_e prio_q;
  noc_pkg::dir_e locked_sel_q;
  logic          lock_q;
  noc_pkg::dir_e pick_idx;
  logic          pick_found;
  noc_pkg::dir_e sel;
  noc_pkg::dir_e prio_next;
  logic          xfer;

  // First requester at or after the priority pointer
  always_comb begin
    int unsigned cand;
    pick_found = 1'b0;
    pick_idx   = prio_q;
    for (int unsigned i = 0; i < noc_pkg::num_dirs; i++) begin
      cand = prio_q + i;
      if (cand >= noc_pkg::num_dirs) cand = cand - noc_pkg::num_dirs;
      if (!pick_found && req_i[cand]) begin
        pick_found = 1'b1;
        pick_idx   = noc_pkg::dir_e'(cand);
      end
    end
  end

  // A stalled output keeps its winner until the transfer
  assign sel  = lock_q ? locked_sel_q : pick_idx;
  assign xfer = out.valid && out.ready;

  assign out.valid   = lock_q || pick_found;
  assign out.dst     = dst_i[sel];
  assign out.payload = payload_i[sel];

  assign grant_o   = xfer ? (noc_pkg::dir_mask_t'(1) << sel) : '0;
  assign prio_next = (sel == noc_pkg::dir_local) ? noc_pkg::dir_north
                                                 : noc_pkg::dir_e'(sel + 1);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q       <= noc_pkg::dir_north;
      locked_sel_q <= noc_pkg::dir_north;
      lock_q       <= 1'b0;
    end else if (xfer) begin
      prio_q <= prio_next;
      lock_q <= 1'b0;
    end else if (out.valid) begin
      locked_sel_q <= sel;
      lock_q       <= 1'b1;
    end
  end

endmodule

// File: logic/noc_input_port.sv
// Router input port: flit FIFO plus XY route decision for the head flit
`timescale 1ns/1ns

module noc_input_port #(
  parameter int unsigned payload_width = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  noc_link_if.receiver             in,
  input  noc_pkg::xy_id_t          node_id_i,
  input  logic                     pop_i,
  output noc_pkg::xy_id_t          head_dst_o,
  output logic [payload_width-1:0] head_payload_o,
  output noc_pkg::dir_mask_t       route_req_o
);

  noc_pkg::xy_id_t          dst_q     [noc_pkg::fifo_depth];
  logic [payload_width-1:0] payload_q [noc_pkg::fifo_depth];

  noc_pkg::fifo_ptr_t wr_ptr_q;
  noc_pkg::fifo_ptr_t rd_ptr_q;
  noc_pkg::fifo_cnt_t count_q;
  logic               push;
  logic               empty;
  logic               full;

  noc_pkg::coord_t node_x;
  noc_pkg::coord_t node_y;
  noc_pkg::coord_t dst_x;
  noc_pkg::coord_t dst_y;

  assign full     = (count_q == noc_pkg::fifo_cnt_t'(noc_pkg::fifo_depth));
  assign empty    = (count_q == '0);
  assign in.ready = !full;
  assign push     = in.valid && in.ready;

  always_ff @(posedge clk_i) begin
    if (push) begin
      dst_q[wr_ptr_q]     <= in.dst;
      payload_q[wr_ptr_q] <= in.payload;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == noc_pkg::fifo_ptr_t'(noc_pkg::fifo_depth - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      // Pop only arrives for a granted, non-empty head
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::fifo_ptr_t'(noc_pkg::fifo_depth - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_dst_o     = dst_q[rd_ptr_q];
  assign head_payload_o = payload_q[rd_ptr_q];

  assign node_x = node_id_i[noc_pkg::coord_width +: noc_pkg::coord_width];
  assign node_y = node_id_i[0 +: noc_pkg::coord_width];
  assign dst_x  = head_dst_o[noc_pkg::coord_width +: noc_pkg::coord_width];
  assign dst_y  = head_dst_o[0 +: noc_pkg::coord_width];

  // X first, then Y, else eject locally
  always_comb begin
    route_req_o = '0;
    if (!empty) begin
      if (dst_x > node_x)      route_req_o[noc_pkg::dir_east]  = 1'b1;
      else if (dst_x < node_x) route_req_o[noc_pkg::dir_west]  = 1'b1;
      else if (dst_y > node_y) route_req_o[noc_pkg::dir_north] = 1'b1;
      else if (dst_y < node_y) route_req_o[noc_pkg::dir_south] = 1'b1;
      else                     route_req_o[noc_pkg::dir_local] = 1'b1;
    end
  end

endmodule

// File: logic/noc_link_if.sv
// Single-flit valid/ready link carrying a destination and a payload
`timescale 1ns/1ns

interface noc_link_if #(
  parameter int unsigned payload_width = 32
) ();

  logic                     valid;
  logic                     ready;
  noc_pkg::xy_id_t          dst;
  logic [payload_width-1:0] payload;

  modport sender (
    output valid,
    output dst,
    output payload,
    input  ready
  );

  modport receiver (
    input  valid,
    input  dst,
    input  payload,
    output ready
  );

endinterface

// File: logic/noc_pkg.sv
// Shared mesh sizes, direction encoding and flit types of the router node

package noc_pkg;

  // Square mesh, 4 columns by 4 rows
  localparam int unsigned mesh_dim = 4;

  // North, East, South, West and Local
  localparam int unsigned num_dirs = 5;

  // Entries per input port
  localparam int unsigned fifo_depth = 2;

  localparam int unsigned narrow_payload_width = 32;
  localparam int unsigned wide_payload_width   = 64;

  localparam int unsigned coord_width    = $clog2(mesh_dim);
  localparam int unsigned xy_id_width    = 2 * coord_width;
  localparam int unsigned fifo_ptr_width = $clog2(fifo_depth);
  localparam int unsigned fifo_cnt_width = $clog2(fifo_depth + 1);

  // One mesh coordinate
  typedef logic [coord_width-1:0] coord_t;

  // Node position or flit destination, x in the upper half
  typedef logic [xy_id_width-1:0] xy_id_t;

  // Output and input port numbering
  typedef enum logic [2:0] {
    dir_north = 3'd0,
    dir_east  = 3'd1,
    dir_south = 3'd2,
    dir_west  = 3'd3,
    dir_local = 3'd4
  } dir_e;

  typedef logic [narrow_payload_width-1:0] narrow_payload_t;
  typedef logic [wide_payload_width-1:0]   wide_payload_t;

  // Destination in the upper bits, payload below
  typedef logic [xy_id_width+narrow_payload_width-1:0] narrow_flit_t;
  typedef logic [xy_id_width+wide_payload_width-1:0]   wide_flit_t;

  // One bit per direction, for route requests and grants
  typedef logic [num_dirs-1:0] dir_mask_t;

  typedef logic [fifo_ptr_width-1:0] fifo_ptr_t;
  typedef logic [fifo_cnt_width-1:0] fifo_cnt_t;

endpackage
